//--- rtl/periph_pkg.sv
// Address map, UART timing constants and queue depth
// Address word union with the RAM and IO page views

`default_nettype none

package periph_pkg;

    // UART timing
    localparam int CLK_FREQ     = 1_843_200;
    localparam int BAUD_RATE    = 115200;
    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;  // 16
    localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

    localparam int RX_QUEUE_LEN = 8;

    // RAM at the bottom of the address space, 4 KiB
    localparam int RAM_WORDS = 1024;

    // Hardware register page
    localparam logic [15:0] IO_PAGE         = 16'hFF00;
    localparam logic [13:0] REG_UART_DATA   = 14'd0;
    localparam logic [13:0] REG_UART_STATUS = 14'd1;

    // One bus address seen as a RAM location or as a register in the IO page
    typedef union packed {
        struct packed {
            logic [19:0] high;      // Must be zero for a RAM hit
            logic [9:0]  word_idx;
            logic [1:0]  byte_off;
        } ram;
        struct packed {
            logic [15:0] page;
            logic [13:0] reg_idx;
            logic [1:0]  byte_off;
        } io;
    } bus_addr_u;

endpackage

`default_nettype wire

//--- rtl/uart_rx.sv
// UART receiver
// Start edge detection, mid-bit sampling and stop bit check

`default_nettype none

module uart_rx import periph_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       rst_n,
    input  wire logic       rx_i,
    output logic            valid_o,
    output logic [7:0]      data_o
);

    logic [2:0]            rx_sync;   // Two sync flops plus previous value
    logic                  rx_s;
    logic                  start_edge;
    logic                  active;
    logic [3:0]            bit_idx;   // 0 start, 1..8 data, 9 stop
    logic [BAUD_CNT_W-1:0] cnt;
    logic [BAUD_CNT_W-1:0] cnt_end;
    logic                  sample;

    assign rx_s       = rx_sync[1];
    assign start_edge = rx_sync[2] & ~rx_sync[1];

    // Half a bit to reach the middle of the start bit, full bits after that
    assign cnt_end = (bit_idx == 4'd0) ? BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1)
                                       : BAUD_CNT_W'(CLKS_PER_BIT - 1);
    assign sample  = active && (cnt == cnt_end);

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            rx_sync <= 3'b111;
            active  <= 1'b0;
            bit_idx <= '0;
            cnt     <= '0;
            valid_o <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[1:0], rx_i};
            valid_o <= 1'b0;
            if (!active) begin
                if (start_edge) begin
                    active  <= 1'b1;
                    bit_idx <= '0;
                    cnt     <= '0;
                end
            end else if (sample) begin
                cnt     <= '0;
                bit_idx <= bit_idx + 4'd1;
                if (bit_idx == 4'd0 && rx_s) begin
                    active <= 1'b0;  // Glitch, not a start bit
                end else if (bit_idx == 4'd9) begin
                    active  <= 1'b0;
                    valid_o <= rx_s;  // Frame dropped if stop bit is low
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk_i) begin
        if (sample && bit_idx != 4'd0 && bit_idx != 4'd9) begin
            data_o <= {rx_s, data_o[7:1]};
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_tx.sv
// UART transmitter
// Frames a byte with start and stop bits, ready while idle

`default_nettype none

module uart_tx import periph_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       rst_n,
    input  wire logic       valid_i,
    input  wire logic [7:0] data_i,
    output logic            ready_o,
    output logic            tx_o
);

    logic [9:0]            shreg;
    logic [3:0]            bit_cnt;
    logic [BAUD_CNT_W-1:0] cnt;

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            shreg   <= '1;
            bit_cnt <= '0;
            cnt     <= '0;
            ready_o <= 1'b1;
            tx_o    <= 1'b1;
        end else begin
            tx_o <= shreg[0];  // Registered line output
            if (ready_o) begin
                if (valid_i) begin
                    shreg   <= {1'b1, data_i, 1'b0};
                    bit_cnt <= '0;
                    cnt     <= '0;
                    ready_o <= 1'b0;
                end
            end else if (cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1)) begin
                cnt   <= '0;
                shreg <= {1'b1, shreg[9:1]};  // Shift in idle level
                if (bit_cnt == 4'd9) begin
                    ready_o <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_iface.sv
// UART block with receiver, transmitter and the receive queue
// Queue slots collapse toward the head one step per cycle

`default_nettype none

module uart_iface import periph_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       rst_n,
    input  wire logic       we_i,
    input  wire logic [7:0] wdata_i,
    output logic            wbusy_o,
    input  wire logic       read_i,
    output logic            rvalid_o,
    output logic [7:0]      rdata_o,
    input  wire logic       rx_i,
    output logic            tx_o
);

    logic                    tx_ready;
    logic                    rx_valid;
    logic [7:0]              rx_data;
    logic [RX_QUEUE_LEN-1:0] q_valid;   // Slot 0 is the head
    logic [7:0]              q_data [RX_QUEUE_LEN];

    uart_tx u_tx (
        .clk_i   (clk_i),
        .rst_n   (rst_n),
        .valid_i (we_i),
        .data_i  (wdata_i),
        .ready_o (tx_ready),
        .tx_o    (tx_o)
    );

    uart_rx u_rx (
        .clk_i   (clk_i),
        .rst_n   (rst_n),
        .rx_i    (rx_i),
        .valid_o (rx_valid),
        .data_o  (rx_data)
    );

    assign wbusy_o  = ~tx_ready;
    assign rvalid_o = q_valid[0];
    assign rdata_o  = q_data[0];

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            q_valid <= '0;
        end else begin
            for (int i = 0; i < RX_QUEUE_LEN - 1; i++) begin
                if (!q_valid[i]) begin
                    q_valid[i]   <= q_valid[i+1];
                    q_valid[i+1] <= 1'b0;  // Overridden if slot i+1 also moves
                end
            end
            if (rx_valid) begin
                q_valid[RX_QUEUE_LEN-1] <= 1'b1;  // Overwrites the tail when full
            end
            if (q_valid[0] && read_i) begin
                q_valid[0] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RX_QUEUE_LEN - 1; i++) begin
            if (!q_valid[i]) begin
                q_data[i] <= q_data[i+1];
            end
        end
        if (rx_valid) begin
            q_data[RX_QUEUE_LEN-1] <= rx_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/hwreg_iface.sv
// Hardware register page
// UART data and status registers, registered read word

`default_nettype none

module hwreg_iface import periph_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        rst_n,
    input  wire logic        req_i,
    input  wire logic        we_i,
    input  wire logic [13:0] reg_idx_i,
    input  wire logic [31:0] wdata_i,
    output logic             rvalid_o,
    output logic [31:0]      rdata_o,
    input  wire logic        rx_i,
    output logic             tx_o
);

    logic       uart_req;
    logic       uart_wbusy;
    logic       head_valid;
    logic [7:0] head_data;

    assign uart_req = req_i && (reg_idx_i == REG_UART_DATA);

    uart_iface u_uart (
        .clk_i    (clk_i),
        .rst_n    (rst_n),
        .we_i     (uart_req && we_i),
        .wdata_i  (wdata_i[7:0]),
        .wbusy_o  (uart_wbusy),
        .read_i   (uart_req && !we_i),  // Pops the head
        .rvalid_o (head_valid),
        .rdata_o  (head_data),
        .rx_i     (rx_i),
        .tx_o     (tx_o)
    );

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_o <= 1'b0;
        end else begin
            rvalid_o <= req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        case (reg_idx_i)
            REG_UART_DATA:   rdata_o <= head_valid ? {24'h0, head_data} : '1;
            REG_UART_STATUS: rdata_o <= {30'h0, head_valid, uart_wbusy};
            default:         rdata_o <= '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/ram32.sv
// Word-wide RAM with byte-enable writes and registered read

`default_nettype none

module ram32 import periph_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        rst_n,
    input  wire logic        req_i,
    input  wire logic        we_i,
    input  wire logic [3:0]  be_i,
    input  wire logic [9:0]  word_idx_i,
    input  wire logic [31:0] wdata_i,
    output logic             rvalid_o,
    output logic [31:0]      rdata_o
);

    logic [31:0] mem [RAM_WORDS];

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_o <= 1'b0;
        end else begin
            rvalid_o <= req_i;
        end
    end

    // Read returns the old word when the same edge writes it
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rdata_o <= mem[word_idx_i];
            if (we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (be_i[b]) begin
                        mem[word_idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/periph_top.sv
// Peripheral subsystem top level
// Region decode, error flag and read data return mux

`default_nettype none

module periph_top import periph_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        rst_n,
    input  wire logic        req_i,
    input  wire logic        we_i,
    input  wire logic [31:0] addr_i,
    input  wire logic [3:0]  be_i,
    input  wire logic [31:0] wdata_i,
    output logic             rvalid_o,
    output logic             err_o,
    output logic [31:0]      rdata_o,
    input  wire logic        rx_i,
    output logic             tx_o
);

    bus_addr_u   bus_addr;
    logic        ram_sel;
    logic        io_sel;
    logic        req_q;
    logic        ram_rvalid;
    logic [31:0] ram_rdata;
    logic        hw_rvalid;
    logic [31:0] hw_rdata;

    assign bus_addr = addr_i;
    assign ram_sel  = (bus_addr.ram.high == '0);
    assign io_sel   = (bus_addr.io.page == IO_PAGE);

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else begin
            req_q <= req_i;
        end
    end

    assign rvalid_o = req_q;
    assign err_o    = req_q & ~(ram_rvalid | hw_rvalid);  // No region answered
    assign rdata_o  = hw_rvalid ? hw_rdata : ram_rdata;

    ram32 u_ram (
        .clk_i      (clk_i),
        .rst_n      (rst_n),
        .req_i      (req_i && ram_sel),
        .we_i       (we_i),
        .be_i       (be_i),
        .word_idx_i (bus_addr.ram.word_idx),
        .wdata_i    (wdata_i),
        .rvalid_o   (ram_rvalid),
        .rdata_o    (ram_rdata)
    );

    hwreg_iface u_hwreg (
        .clk_i     (clk_i),
        .rst_n     (rst_n),
        .req_i     (req_i && io_sel),
        .we_i      (we_i),
        .reg_idx_i (bus_addr.io.reg_idx),
        .wdata_i   (wdata_i),
        .rvalid_o  (hw_rvalid),
        .rdata_o   (hw_rdata),
        .rx_i      (rx_i),
        .tx_o      (tx_o)
    );

endmodule

`default_nettype wire

//--- sim/periph_checker.sv
// Response checker for bus reads and writes and for frames on tx_o
// Prints one line per test and the closing counts

`default_nettype none

module periph_checker import periph_pkg::*; (
    input  wire logic         clk_i,
    input  wire logic         rst_n,
    input  wire logic         rvalid_i,
    input  wire logic         err_i,
    input  wire logic [31:0]  rdata_i,
    input  wire logic         tx_i,
    input  wire logic [127:0] bus_name_i,
    input  wire logic [31:0]  exp_data_i,
    input  wire logic         exp_err_i,
    input  wire logic         chk_data_i,   // Data compared only when set
    input  wire logic         tx_armed_i,
    input  wire logic [127:0] tx_name_i,
    input  wire logic [7:0]   tx_exp_i,
    input  wire logic         finish_i,
    output int                frames_o,
    output int                fails_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int         passes;
    logic [7:0] rx_byte;
    logic       stop_bit;

    initial begin
        frames_o = 0;
        fails_o  = 0;
        passes   = 0;
    end

    always @(posedge clk_i) begin
        if (rst_n && rvalid_i) begin
            if (err_i !== exp_err_i) begin
                $display("FAILED %0s expected err %0d actual err %0d",
                         bus_name_i, exp_err_i, err_i);
                fails_o++;
            end else if (chk_data_i && rdata_i !== exp_data_i) begin
                $display("FAILED %0s expected %08h actual %08h",
                         bus_name_i, exp_data_i, rdata_i);
                fails_o++;
            end else begin
                $display("ok     %0s", bus_name_i);
                passes++;
            end
        end
        if (finish_i) begin
            $display("tests: %0d passed, %0d failed", passes, fails_o);
        end
    end

    // Frame decoder, samples each bit in its middle
    always begin
        @(posedge clk_i);
        if (rst_n && tx_i == 1'b0) begin
            repeat (CLKS_PER_BIT / 2) @(posedge clk_i);
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(posedge clk_i);
                rx_byte[i] = tx_i;
            end
            repeat (CLKS_PER_BIT) @(posedge clk_i);
            stop_bit = tx_i;
            if (!tx_armed_i) begin
                $display("unexpected frame on tx_o carrying %02h", rx_byte);
                fails_o++;
            end else if (!stop_bit) begin
                $display("frame on tx_o for %0s has a low stop bit", tx_name_i);
                fails_o++;
            end else if (rx_byte !== tx_exp_i) begin
                $display("FAILED %0s expected %02h actual %02h", tx_name_i, tx_exp_i, rx_byte);
                fails_o++;
            end else begin
                $display("ok     %0s", tx_name_i);
                passes++;
            end
            frames_o++;
        end
    end

endmodule

`default_nettype wire

//--- sim/periph_properties.sv
// Bus response timing, error decode and transmitter idle line assertions
// Bound into periph_top

`default_nettype none

module periph_properties (
    input wire logic        clk_i,
    input wire logic        rst_n,
    input wire logic        req_i,
    input wire logic [31:0] addr_i,
    input wire logic        rvalid_o,
    input wire logic        err_o,
    input wire logic        tx_o,
    input wire logic        tx_ready_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // Every request is answered exactly one cycle later
    a_rvalid_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n)
        rvalid_o == $past(req_i))
        else $error("rvalid_o does not follow req_i by one cycle");

    // Error only on the answer to an address outside the RAM and the IO page
    a_err_decode: assert property (@(posedge clk_i) disable iff (!rst_n)
        err_o == (rvalid_o && $past(addr_i[31:12] != 20'h0 && addr_i[31:16] != 16'hFF00)))
        else $error("err_o does not match the region of the request address");

    a_tx_idle_high: assert property (@(posedge clk_i) disable iff (!rst_n)
        tx_ready_i |-> tx_o)
        else $error("tx_o low while the transmitter is idle");

endmodule

bind periph_top periph_properties u_props (
    .clk_i      (clk_i),
    .rst_n      (rst_n),
    .req_i      (req_i),
    .addr_i     (addr_i),
    .rvalid_o   (rvalid_o),
    .err_o      (err_o),
    .tx_o       (tx_o),
    .tx_ready_i (u_hwreg.u_uart.tx_ready)
);

`default_nettype wire

//--- sim/tb_periph.sv
// Testbench top for the peripheral subsystem
// Clock, reset, case file loading, bus and serial stimulus, timeout

`default_nettype none

module tb_periph import periph_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CASES = 64;

    logic        clk_i = 1'b0;
    logic        rst_n;
    logic        req_i;
    logic        we_i;
    logic [31:0] addr_i;
    logic [3:0]  be_i;
    logic [31:0] wdata_i;
    logic        rx_i;
    wire logic        rvalid_o;
    wire logic        err_o;
    wire logic [31:0] rdata_o;
    wire logic        tx_o;

    logic [127:0] bus_name, tx_name;
    logic [31:0]  exp_data;
    logic         exp_err, chk_data, tx_armed, finish;
    logic [7:0]   tx_exp;
    int           frames, fails;

    logic [7:0]   c_op [MAX_CASES];
    logic [127:0] c_name [MAX_CASES];
    logic [31:0]  c_addr [MAX_CASES];
    logic [31:0]  c_data [MAX_CASES];
    logic [3:0]   c_be [MAX_CASES];
    logic [31:0]  c_exp [MAX_CASES];
    logic         c_err [MAX_CASES];
    int           n_cases;
    logic [31:0]  ram_model [int];
    int           seed = 32'h05ea8137;
    int           cycle_cnt = 0;
    int           cycle_limit = 0;

    periph_top u_dut (.*);

    periph_checker u_checker (
        .clk_i (clk_i), .rst_n (rst_n),
        .rvalid_i (rvalid_o), .err_i (err_o), .rdata_i (rdata_o), .tx_i (tx_o),
        .bus_name_i (bus_name), .exp_data_i (exp_data), .exp_err_i (exp_err),
        .chk_data_i (chk_data), .tx_armed_i (tx_armed), .tx_name_i (tx_name),
        .tx_exp_i (tx_exp), .finish_i (finish), .frames_o (frames), .fails_o (fails)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles, run stopped", cycle_cnt);
            $display("tests failed");
            $finish;
        end
    end

    task automatic load_cases();
        int           fd;
        int           r;
        logic [127:0] tok;
        logic [959:0] line_buf;
        fd = $fopen("sim/periph_cases.txt", "r");
        n_cases = 0;
        if (fd == 0) begin
            $display("cannot open sim/periph_cases.txt");
            return;
        end
        while (!$feof(fd) && n_cases < MAX_CASES) begin
            r = $fscanf(fd, "%s", tok);
            if (r != 1) break;
            if (tok[7:0] == "#") begin
                r = $fgets(line_buf, fd);  // Skip comment line
            end else begin
                c_op[n_cases] = tok[7:0];
                r = $fscanf(fd, "%s %h %h %h %h %h", c_name[n_cases], c_addr[n_cases],
                            c_data[n_cases], c_be[n_cases], c_exp[n_cases], c_err[n_cases]);
                n_cases++;
            end
        end
        $fclose(fd);
    endtask

    function automatic logic [31:0] merge_lanes(logic [31:0] old_w, logic [31:0] new_w,
                                                logic [3:0] be);
        logic [31:0] w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) w[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return w;
    endfunction

    task automatic bus_access(input logic wr, input int i, input logic [31:0] expect_w);
        @(posedge clk_i);
        req_i    <= 1'b1;
        we_i     <= wr;
        addr_i   <= c_addr[i];
        be_i     <= c_be[i];
        wdata_i  <= c_data[i];
        bus_name <= c_name[i];
        exp_err  <= c_err[i];
        exp_data <= expect_w;
        chk_data <= !wr && !c_err[i];  // Data of an error response is undefined
        @(posedge clk_i);
        req_i <= 1'b0;
        do @(posedge clk_i); while (!rvalid_o);
    endtask

    task automatic send_serial(input logic [7:0] b);
        int gap;
        logic [9:0] frame;
        gap = CLKS_PER_BIT + ($unsigned($random(seed)) % CLKS_PER_BIT);
        frame = {1'b1, b, 1'b0};
        repeat (gap) @(posedge clk_i);
        for (int k = 0; k < 10; k++) begin
            rx_i <= frame[k];
            repeat (CLKS_PER_BIT) @(posedge clk_i);
        end
        repeat (CLKS_PER_BIT) @(posedge clk_i);  // Lets the queue settle
    endtask

    task automatic expect_frame(input int i);
        int seen;
        seen = frames;
        tx_exp   <= c_exp[i][7:0];
        tx_name  <= c_name[i];
        tx_armed <= 1'b1;
        while (frames == seen) @(posedge clk_i);
        tx_armed <= 1'b0;
    endtask

    initial begin
        logic ram_hit;
        logic [31:0] exp_w;
        rst_n = 1'b0;
        req_i = 1'b0;
        we_i = 1'b0;
        addr_i = '0;
        be_i = '0;
        wdata_i = '0;
        rx_i = 1'b1;
        bus_name = '0;
        tx_name = '0;
        exp_data = '0;
        exp_err = 1'b0;
        chk_data = 1'b0;
        tx_armed = 1'b0;
        tx_exp = '0;
        finish = 1'b0;
        load_cases();
        cycle_limit = n_cases * 12 * CLKS_PER_BIT + 200;
        repeat (8) @(posedge clk_i);
        rst_n <= 1'b1;
        for (int i = 0; i < n_cases; i++) begin
            ram_hit = (c_addr[i][31:12] == 20'h0);
            case (c_op[i])
                "W": begin
                    if (ram_hit) begin
                        exp_w = ram_model.exists(int'(c_addr[i][11:2])) ?
                                ram_model[int'(c_addr[i][11:2])] : 32'hxxxx_xxxx;
                        ram_model[int'(c_addr[i][11:2])] = merge_lanes(exp_w, c_data[i], c_be[i]);
                    end
                    bus_access(1'b1, i, '0);
                end
                "R": begin
                    exp_w = (ram_hit && ram_model.exists(int'(c_addr[i][11:2]))) ?
                            ram_model[int'(c_addr[i][11:2])] : c_exp[i];
                    bus_access(1'b0, i, exp_w);
                end
                "S": send_serial(c_data[i][7:0]);
                "T": expect_frame(i);
                default: $display("unknown operation in case %0d", i);
            endcase
        end
        repeat (4) @(posedge clk_i);
        finish <= 1'b1;
        @(posedge clk_i);
        finish <= 1'b0;
        @(posedge clk_i);
        if (fails == 0 && n_cases > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/periph_cases.txt
# op name addr wdata be expect err  (hex; W write, R read, S serial in, T frame out)
# RAM read data comes from the merged write model, expect is used elsewhere
W ram_full 00000010 11223344 f 0 0
W ram_lanes 00000010 aabbccdd 5 0 0
R ram_merge 00000010 0 0 0 0
W ram_last 00000ffc deadbeef f 0 0
R ram_last_rd 00000ffc 0 0 0 0
R err_read 00001000 0 0 0 1
W err_write 80000000 12345678 f 0 1
R reg_unused ff000010 0 0 0 0
W tx_write ff000000 5a f 0 0
R tx_busy ff000004 0 0 1 0
W tx_dropped ff000000 c3 f 0 0
T tx_frame 0 0 0 5a 0
S rx_a 0 31 0 0 0
S rx_b 0 32 0 0 0
R rx_status ff000004 0 0 2 0
R rx_first ff000000 0 0 31 0
R rx_second ff000000 0 0 32 0
R rx_empty ff000000 0 0 ffffffff 0
S q_in0 0 41 0 0 0
S q_in1 0 42 0 0 0
S q_in2 0 43 0 0 0
S q_in3 0 44 0 0 0
S q_in4 0 45 0 0 0
S q_in5 0 46 0 0 0
S q_in6 0 47 0 0 0
S q_in7 0 48 0 0 0
R q_rd0 ff000000 0 0 41 0
R q_rd1 ff000000 0 0 42 0
R q_rd2 ff000000 0 0 43 0
R q_rd3 ff000000 0 0 44 0
R q_rd4 ff000000 0 0 45 0
R q_rd5 ff000000 0 0 46 0
R q_rd6 ff000000 0 0 47 0
R q_rd7 ff000000 0 0 48 0
R q_ninth ff000000 0 0 ffffffff 0

//--- filelist.f
rtl/periph_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_iface.sv
rtl/hwreg_iface.sv
rtl/ram32.sv
rtl/periph_top.sv
sim/periph_checker.sv
sim/periph_properties.sv
sim/tb_periph.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_periph -f filelist.f \
    && ./obj_dir/Vtb_periph > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "^all tests passed$" sim.log && exit 0 || exit 1
